/* design/panel_pkg.sv */
// panel geometry and frame RAM address layout
// address is row, then column, then byte select (byte_sel 0 is the low byte)
package panel_pkg;

    localparam int brightness_levels = 6;
    localparam int bytes_per_pixel = 2;

    localparam int default_width = 64;
    localparam int default_height = 32;

    function automatic int row_bits_of(input int height);
        return $clog2(height);
    endfunction

    function automatic int col_bits_of(input int width);
        return $clog2(width);
    endfunction

    // full RAM address width, byte select included
    function automatic int addr_bits_of(input int width, input int height);
        return row_bits_of(height) + col_bits_of(width) + $clog2(bytes_per_pixel);
    endfunction

    typedef logic [brightness_levels-1:0] brightness_t;

endpackage

/* design/cmd_pkg.sv */
// command byte codes and the decoder-side types
package cmd_pkg;

    typedef logic [7:0] byte_t;

    // colour plane switches
    localparam byte_t cmd_red_on = "R";
    localparam byte_t cmd_red_off = "r";
    localparam byte_t cmd_green_on = "G";
    localparam byte_t cmd_green_off = "g";
    localparam byte_t cmd_blue_on = "B";
    localparam byte_t cmd_blue_off = "b";

    // brightness planes, '1' is the first toggle code
    localparam byte_t cmd_plane_first = "1";
    localparam byte_t cmd_all_off = "0";
    localparam byte_t cmd_all_on = "9";

    // multi-byte commands
    localparam byte_t cmd_load_brightness = "T";
    localparam byte_t cmd_blank = "Z";
    localparam byte_t cmd_pixel = "P";

    typedef enum logic [1:0] {
        idle,
        load_brightness,
        pixel,
        blank
    } decoder_state_t;

    typedef enum logic [2:0] {
        channel_on,
        channel_off,
        plane_toggle,
        all_off,
        all_on,
        load
    } setting_op_t;

endpackage

/* design/cmd_decoder.sv */
// command decoder for the LED panel byte stream
// maps single-byte commands to settings ops and dispatches P, T and Z
`timescale 1ns/1ns
module cmd_decoder (
    input  logic                 clk_in,
    input  logic                 reset,
    input  cmd_pkg::byte_t       data_rx,
    input  logic                 data_ready_n,
    input  logic                 pixel_done,
    input  logic                 blank_done,
    output logic                 busy,
    output logic                 ready_for_data,
    output logic                 setting_valid,
    output cmd_pkg::setting_op_t setting_op,
    output cmd_pkg::byte_t       setting_data,
    output logic                 pixel_byte_valid,
    output cmd_pkg::byte_t       pixel_byte,
    output logic                 blank_start
);
    import cmd_pkg::*;
    import panel_pkg::*;

    decoder_state_t state;
    logic accept;
    logic cmd_phase;
    logic is_plane;
    logic decode_valid;
    setting_op_t decode_op;
    byte_t decode_data;

    assign busy = (state != idle);
    assign ready_for_data = (state != blank);
    assign accept = ~data_ready_n && ready_for_data;

    // last pixel write in flight, next byte is already a command
    assign cmd_phase = (state == idle) || (state == pixel && pixel_done);

    assign pixel_byte_valid = accept && state == pixel && !pixel_done;
    assign pixel_byte = data_rx;
    assign blank_start = accept && cmd_phase && data_rx == cmd_blank;

    assign is_plane = data_rx >= cmd_plane_first &&
                      data_rx < cmd_plane_first + byte_t'(brightness_levels);

    always_comb begin
        decode_valid = 1'b1;
        decode_op = channel_on;
        decode_data = '0;
        case (data_rx)
            cmd_red_on: decode_data = 8'd0;
            cmd_red_off: decode_op = channel_off;
            cmd_green_on: decode_data = 8'd1;
            cmd_green_off: begin
                decode_op = channel_off;
                decode_data = 8'd1;
            end
            cmd_blue_on: decode_data = 8'd2;
            cmd_blue_off: begin
                decode_op = channel_off;
                decode_data = 8'd2;
            end
            cmd_all_off: decode_op = all_off;
            cmd_all_on: decode_op = all_on;
            default: begin
                // plane number 1..6
                decode_op = plane_toggle;
                decode_data = data_rx - cmd_plane_first + 8'd1;
                decode_valid = is_plane;
            end
        endcase
        if (state == load_brightness) begin
            decode_valid = 1'b1;
            decode_op = load;
            decode_data = data_rx;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= idle;
            setting_valid <= 1'b0;
        end else begin
            setting_valid <= accept && decode_valid &&
                             (cmd_phase || state == load_brightness);
            if (state == load_brightness && accept) begin
                state <= idle;
            end
            if (state == blank && blank_done) begin
                state <= idle;
            end
            if (accept && cmd_phase) begin
                case (data_rx)
                    cmd_load_brightness: state <= load_brightness;
                    cmd_pixel: state <= pixel;
                    cmd_blank: state <= blank;
                    default: state <= idle;
                endcase
            end else if (state == pixel && pixel_done) begin
                state <= idle;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            setting_op <= decode_op;
            setting_data <= decode_data;
        end
    end

endmodule

/* design/pixel_writer.sv */
// pixel writer for the P command
// takes row, column and two data bytes, then issues two byte writes
`timescale 1ns/1ns
module pixel_writer #(
    parameter int panel_width = panel_pkg::default_width,
    parameter int panel_height = panel_pkg::default_height
) (
    input  logic                 clk_in,
    input  logic                 reset,
    input  logic                 pixel_byte_valid,
    input  cmd_pkg::byte_t       pixel_byte,
    output logic                 write_request,
    output logic [panel_pkg::addr_bits_of(panel_width, panel_height)-1:0] write_address,
    output cmd_pkg::byte_t       write_data,
    output logic                 pixel_done
);
    import panel_pkg::*;

    localparam int row_bits = row_bits_of(panel_height);
    localparam int col_bits = col_bits_of(panel_width);
    localparam int sel_bits = addr_bits_of(panel_width, panel_height) - row_bits - col_bits;

    logic [1:0] arg_count;
    logic [row_bits-1:0] row;
    logic [col_bits-1:0] col;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            arg_count <= 2'd0;
            write_request <= 1'b0;
            pixel_done <= 1'b0;
        end else begin
            write_request <= pixel_byte_valid && arg_count[1];
            pixel_done <= pixel_byte_valid && arg_count == 2'd3;
            if (pixel_byte_valid) begin
                // wraps back to the row byte after the second data byte
                arg_count <= arg_count + 2'd1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (pixel_byte_valid) begin
            case (arg_count)
                2'd0: row <= pixel_byte[row_bits-1:0];
                2'd1: col <= pixel_byte[col_bits-1:0];
                // first data byte is the high byte
                2'd2: write_address <= {row, col, sel_bits'(1)};
                default: write_address <= {row, col, sel_bits'(0)};
            endcase
            write_data <= pixel_byte;
        end
    end

endmodule

/* design/panel_blanker.sv */
// panel blanker, sweeps every frame RAM address once per start
`timescale 1ns/1ns
module panel_blanker #(
    parameter int panel_width = panel_pkg::default_width,
    parameter int panel_height = panel_pkg::default_height
) (
    input  logic clk_in,
    input  logic reset,
    input  logic blank_start,
    output logic write_request,
    output logic [panel_pkg::addr_bits_of(panel_width, panel_height)-1:0] write_address,
    output logic blank_done
);
    import panel_pkg::*;

    localparam int addr_bits = addr_bits_of(panel_width, panel_height);
    localparam int depth = panel_width * panel_height * bytes_per_pixel;
    localparam logic [addr_bits-1:0] last_address = addr_bits'(depth - 1);

    logic active;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            active <= 1'b0;
            write_address <= '0;
        end else if (blank_start) begin
            active <= 1'b1;
            write_address <= '0;
        end else if (active) begin
            if (write_address == last_address) begin
                active <= 1'b0;
            end else begin
                write_address <= write_address + 1'b1;
            end
        end
    end

    // one zero write per cycle while sweeping
    assign write_request = active;
    assign blank_done = active && write_address == last_address;

endmodule

/* design/display_settings.sv */
// display settings, colour-plane and brightness-plane enables
`timescale 1ns/1ns
module display_settings (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic                  setting_valid,
    input  cmd_pkg::setting_op_t  setting_op,
    input  cmd_pkg::byte_t        setting_data,
    output logic [2:0]            rgb_enable,
    output panel_pkg::brightness_t brightness_enable
);
    import cmd_pkg::*;
    import panel_pkg::*;

    localparam int plane_bits = $clog2(brightness_levels);

    logic [plane_bits-1:0] plane_index;

    // plane 1 is the top bit
    assign plane_index = plane_bits'(brightness_levels) - plane_bits'(setting_data);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_enable <= 3'b111;
            brightness_enable <= '1;
        end else if (setting_valid) begin
            case (setting_op)
                channel_on: rgb_enable[setting_data[1:0]] <= 1'b1;
                channel_off: rgb_enable[setting_data[1:0]] <= 1'b0;
                plane_toggle: begin
                    brightness_enable[plane_index] <= ~brightness_enable[plane_index];
                end
                all_off: brightness_enable <= '0;
                all_on: brightness_enable <= '1;
                load: brightness_enable <= setting_data[brightness_levels-1:0];
                default: brightness_enable <= brightness_enable;
            endcase
        end
    end

endmodule

/* design/ram_port.sv */
// frame RAM write port
// registers whichever requester is active, blank writes carry zero data
`timescale 1ns/1ns
module ram_port #(
    parameter int panel_width = panel_pkg::default_width,
    parameter int panel_height = panel_pkg::default_height
) (
    input  logic           clk_in,
    input  logic           reset,
    input  logic           pixel_request,
    input  logic [panel_pkg::addr_bits_of(panel_width, panel_height)-1:0] pixel_address,
    input  cmd_pkg::byte_t pixel_data,
    input  logic           blank_request,
    input  logic [panel_pkg::addr_bits_of(panel_width, panel_height)-1:0] blank_address,
    output logic [panel_pkg::addr_bits_of(panel_width, panel_height)-1:0] ram_address,
    output cmd_pkg::byte_t ram_data_out,
    output logic           ram_write_enable
);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            ram_write_enable <= 1'b0;
        end else begin
            ram_write_enable <= pixel_request || blank_request;
        end
    end

    always_ff @(posedge clk_in) begin
        if (blank_request) begin
            ram_address <= blank_address;
            ram_data_out <= '0;
        end else if (pixel_request) begin
            ram_address <= pixel_address;
            ram_data_out <= pixel_data;
        end
    end

endmodule

/* design/led_ctrl_top.sv */
// LED matrix byte-command controller
// decoder, pixel writer, blanker, settings and RAM port
`timescale 1ns/1ns
module led_ctrl_top #(
    parameter int panel_width = panel_pkg::default_width,
    parameter int panel_height = panel_pkg::default_height
) (
    input  logic                   clk_in,
    input  logic                   reset,
    input  cmd_pkg::byte_t         data_rx,
    input  logic                   data_ready_n,
    output logic [2:0]             rgb_enable,
    output panel_pkg::brightness_t brightness_enable,
    output logic [panel_pkg::addr_bits_of(panel_width, panel_height)-1:0] ram_address,
    output cmd_pkg::byte_t         ram_data_out,
    output logic                   ram_write_enable,
    output logic                   busy,
    output logic                   ready_for_data
);
    import cmd_pkg::*;
    import panel_pkg::*;

    localparam int addr_bits = addr_bits_of(panel_width, panel_height);

    logic setting_valid;
    setting_op_t setting_op;
    byte_t setting_data;
    logic pixel_byte_valid;
    byte_t pixel_byte;
    logic pixel_done;
    logic blank_start;
    logic blank_done;
    logic pixel_request;
    logic [addr_bits-1:0] pixel_address;
    byte_t pixel_data;
    logic blank_request;
    logic [addr_bits-1:0] blank_address;

    cmd_decoder cmd_decoder_inst (
        .clk_in          (clk_in),
        .reset           (reset),
        .data_rx         (data_rx),
        .data_ready_n    (data_ready_n),
        .pixel_done      (pixel_done),
        .blank_done      (blank_done),
        .busy            (busy),
        .ready_for_data  (ready_for_data),
        .setting_valid   (setting_valid),
        .setting_op      (setting_op),
        .setting_data    (setting_data),
        .pixel_byte_valid(pixel_byte_valid),
        .pixel_byte      (pixel_byte),
        .blank_start     (blank_start)
    );

    pixel_writer #(
        .panel_width (panel_width),
        .panel_height(panel_height)
    ) pixel_writer_inst (
        .clk_in          (clk_in),
        .reset           (reset),
        .pixel_byte_valid(pixel_byte_valid),
        .pixel_byte      (pixel_byte),
        .write_request   (pixel_request),
        .write_address   (pixel_address),
        .write_data      (pixel_data),
        .pixel_done      (pixel_done)
    );

    panel_blanker #(
        .panel_width (panel_width),
        .panel_height(panel_height)
    ) panel_blanker_inst (
        .clk_in       (clk_in),
        .reset        (reset),
        .blank_start  (blank_start),
        .write_request(blank_request),
        .write_address(blank_address),
        .blank_done   (blank_done)
    );

    display_settings display_settings_inst (
        .clk_in           (clk_in),
        .reset            (reset),
        .setting_valid    (setting_valid),
        .setting_op       (setting_op),
        .setting_data     (setting_data),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable)
    );

    ram_port #(
        .panel_width (panel_width),
        .panel_height(panel_height)
    ) ram_port_inst (
        .clk_in          (clk_in),
        .reset           (reset),
        .pixel_request   (pixel_request),
        .pixel_address   (pixel_address),
        .pixel_data      (pixel_data),
        .blank_request   (blank_request),
        .blank_address   (blank_address),
        .ram_address     (ram_address),
        .ram_data_out    (ram_data_out),
        .ram_write_enable(ram_write_enable)
    );

endmodule

/* tb/tb_clock.sv */
// testbench clock source, 10 ns period
`timescale 1ns/1ns
module tb_clock #(
    parameter int half_period = 5
) (
    output logic clk_in
);

    initial begin
        clk_in = 1'b0;
        forever begin
            #half_period clk_in = ~clk_in;
        end
    end

endmodule

/* tb/led_ctrl_properties.sv */
// assertions on the RAM port and flow-control outputs of the controller
`timescale 1ns/1ns
module led_ctrl_properties #(
    parameter int panel_width = panel_pkg::default_width,
    parameter int panel_height = panel_pkg::default_height
) (
    input logic clk_in,
    input logic reset,
    input logic [panel_pkg::addr_bits_of(panel_width, panel_height)-1:0] ram_address,
    input logic ram_write_enable,
    input logic busy,
    input logic ready_for_data
);
    import panel_pkg::*;

    localparam int depth = panel_width * panel_height * bytes_per_pixel;

    no_write_after_reset: assert property (@(posedge clk_in) reset |=> !ram_write_enable)
        else $error("ram_write_enable high in the cycle after reset");

    address_in_range: assert property (@(posedge clk_in) disable iff (reset)
        ram_write_enable |-> int'(ram_address) < depth)
        else $error("ram_address %0d outside the frame RAM", ram_address);

    // only a blank sweep holds off the byte source
    ready_when_idle: assert property (@(posedge clk_in) disable iff (reset)
        !busy |-> ready_for_data)
        else $error("ready_for_data low while the decoder is idle");

endmodule

bind led_ctrl_top led_ctrl_properties #(
    .panel_width (panel_width),
    .panel_height(panel_height)
) led_ctrl_properties_inst (
    .clk_in          (clk_in),
    .reset           (reset),
    .ram_address     (ram_address),
    .ram_write_enable(ram_write_enable),
    .busy            (busy),
    .ready_for_data  (ready_for_data)
);

/* tb/led_ctrl_tb.sv */
// testbench for the LED matrix byte-command controller
// random commands checked against a settings model and a frame RAM mirror
`timescale 1ns/1ns
module led_ctrl_tb;
    import cmd_pkg::*;
    import panel_pkg::*;

    localparam int width = 8;
    localparam int height = 4;
    localparam int depth = width * height * 2;
    localparam int addr_bits = addr_bits_of(width, height);
    localparam int wait_limit = 200;
    localparam byte_t single_codes [16] = '{"R", "r", "G", "g", "B", "b", "0", "1",
                                            "2", "3", "4", "5", "6", "7", "8", "9"};

    logic clk_in;
    logic reset;
    byte_t data_rx;
    logic data_ready_n;
    logic [2:0] rgb_enable;
    brightness_t brightness_enable;
    logic [addr_bits-1:0] ram_address;
    byte_t ram_data_out;
    logic ram_write_enable;
    logic busy;
    logic ready_for_data;

    logic [31:0] rand_state;
    byte_t mirror_ram [depth];
    byte_t model_ram [depth];
    logic [2:0] model_rgb;
    logic [5:0] model_bright;
    int checks;
    int errors;

    tb_clock tb_clock_inst (.clk_in(clk_in));

    led_ctrl_top #(
        .panel_width (width),
        .panel_height(height)
    ) led_ctrl_top_inst (
        .clk_in           (clk_in),
        .reset            (reset),
        .data_rx          (data_rx),
        .data_ready_n     (data_ready_n),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable),
        .ram_address      (ram_address),
        .ram_data_out     (ram_data_out),
        .ram_write_enable (ram_write_enable),
        .busy             (busy),
        .ready_for_data   (ready_for_data)
    );

    // external frame RAM, sampled on the falling edge
    always @(negedge clk_in) begin
        if (ram_write_enable) begin
            mirror_ram[ram_address] = ram_data_out;
        end
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state >> 16;
    endfunction

    function automatic byte_t random_single();
        logic [31:0] pick;
        byte_t value;
        pick = next_random() % 32'd20;
        if (pick < 32'd16) begin
            value = single_codes[pick[3:0]];
        end else begin
            value = byte_t'(next_random());
            // multi-byte commands are exercised elsewhere
            if (value == "T" || value == "P" || value == "Z") begin
                value = 8'h00;
            end
        end
        return value;
    endfunction

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk_in);
            #1;
        end
    endtask

    task automatic send_byte(input byte_t value);
        int waited;
        waited = 0;
        while (!ready_for_data && waited < wait_limit) begin
            idle_cycles(1);
            waited++;
        end
        if (!ready_for_data) begin
            $display("Timeout at %0t: ready_for_data stayed low, byte %h not sent", $time, value);
            errors++;
        end else begin
            data_rx = value;
            data_ready_n = 1'b0;
            idle_cycles(1);
            data_ready_n = 1'b1;
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (busy && waited < wait_limit) begin
            idle_cycles(1);
            waited++;
        end
        if (busy) begin
            $display("Timeout at %0t: busy did not return low", $time);
            errors++;
        end
        // settings and RAM writes land a few cycles later
        idle_cycles(4);
    endtask

    task automatic apply_model(input byte_t value);
        int plane;
        plane = int'(value) - 48;
        case (value)
            "R": model_rgb[0] = 1'b1;
            "r": model_rgb[0] = 1'b0;
            "G": model_rgb[1] = 1'b1;
            "g": model_rgb[1] = 1'b0;
            "B": model_rgb[2] = 1'b1;
            "b": model_rgb[2] = 1'b0;
            "0": model_bright = '0;
            "9": model_bright = '1;
            default: begin
                // plane 1 is the top bit
                if (plane >= 1 && plane <= 6) begin
                    model_bright[6 - plane] = ~model_bright[6 - plane];
                end
            end
        endcase
    endtask

    task automatic write_pixel(input byte_t row, input byte_t col,
                               input byte_t high_byte, input byte_t low_byte);
        int base;
        base = ((int'(row) % height) * width + int'(col) % width) * 2;
        send_byte("P");
        send_byte(row);
        send_byte(col);
        send_byte(high_byte);
        send_byte(low_byte);
        model_ram[base + 1] = high_byte;
        model_ram[base] = low_byte;
    endtask

    task automatic check_settings();
        checks++;
        if (rgb_enable !== model_rgb) begin
            $display("Mismatch at %0t: rgb_enable %b, expected %b", $time, rgb_enable, model_rgb);
            errors++;
        end
        checks++;
        if (brightness_enable !== model_bright) begin
            $display("Mismatch at %0t: brightness_enable %b, expected %b",
                     $time, brightness_enable, model_bright);
            errors++;
        end
    endtask

    task automatic check_ram();
        for (int a = 0; a < depth; a++) begin
            checks++;
            if (mirror_ram[a] !== model_ram[a]) begin
                $display("Mismatch at %0t: RAM[%0d] is %h, expected %h",
                         $time, a, mirror_ram[a], model_ram[a]);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    initial begin
        int start_errors;
        byte_t value;
        rand_state = 32'd5;
        checks = 0;
        errors = 0;
        reset = 1'b1;
        data_rx = 8'h00;
        data_ready_n = 1'b1;
        model_rgb = 3'b111;
        model_bright = '1;
        for (int a = 0; a < depth; a++) begin
            mirror_ram[a] = byte_t'(a) ^ 8'ha5;
            model_ram[a] = byte_t'(a) ^ 8'ha5;
        end
        idle_cycles(5);

        start_errors = errors;
        check_settings();
        checks++;
        if (busy !== 1'b0 || ready_for_data !== 1'b1) begin
            $display("Mismatch at %0t: busy %b ready_for_data %b, expected 0 and 1",
                     $time, busy, ready_for_data);
            errors++;
        end
        reset = 1'b0;
        report_test("reset values", start_errors);

        start_errors = errors;
        for (int i = 0; i < 200; i++) begin
            idle_cycles(int'(next_random() % 32'd3));
            value = random_single();
            send_byte(value);
            apply_model(value);
            wait_idle();
            check_settings();
        end
        report_test("single-byte commands", start_errors);

        start_errors = errors;
        for (int i = 0; i < 10; i++) begin
            value = byte_t'(next_random());
            send_byte("T");
            send_byte(value);
            model_bright = value[5:0];
            wait_idle();
            check_settings();
        end
        report_test("brightness load", start_errors);

        start_errors = errors;
        for (int i = 0; i < 50; i++) begin
            idle_cycles(int'(next_random() % 32'd3));
            write_pixel(byte_t'(next_random()), byte_t'(next_random()),
                        byte_t'(next_random()), byte_t'(next_random()));
            wait_idle();
            check_ram();
        end
        report_test("pixel writes", start_errors);

        start_errors = errors;
        send_byte("Z");
        checks++;
        if (ready_for_data !== 1'b0) begin
            $display("Mismatch at %0t: ready_for_data %b during blanking, expected 0",
                     $time, ready_for_data);
            errors++;
        end
        wait_idle();
        checks++;
        if (ready_for_data !== 1'b1) begin
            $display("Mismatch at %0t: ready_for_data %b after blanking, expected 1",
                     $time, ready_for_data);
            errors++;
        end
        for (int a = 0; a < depth; a++) begin
            model_ram[a] = 8'h00;
        end
        check_ram();
        write_pixel(8'd2, 8'd5, 8'h3c, 8'hc3);
        wait_idle();
        check_ram();
        report_test("panel blank", start_errors);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sim.f */
design/panel_pkg.sv
design/cmd_pkg.sv
design/cmd_decoder.sv
design/pixel_writer.sv
design/panel_blanker.sv
design/display_settings.sv
design/ram_port.sv
design/led_ctrl_top.sv
tb/tb_clock.sv
tb/led_ctrl_properties.sv
tb/led_ctrl_tb.sv

/* Makefile */
# Verilator build and run of the LED controller testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module led_ctrl_tb

run: compile
	./obj_dir/Vled_ctrl_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" sim.log; then echo "simulation FAILED"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
